/* include/dual_issue_cfg.svh */
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// Datapath width of the integer register file and both ALUs.
`define DI_XLEN 32

// Architectural register count.
`define DI_REG_COUNT 32

// Register specifier width, log2 of the register count.
`define DI_REG_AW 5

`endif

/* hw/dual_issue_pkg.sv */
`include "dual_issue_cfg.svh"

package dual_issue_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_sll = 4'd5, // Shift amount is op2[4:0].
		op_srl = 4'd6,
		op_lui = 4'd7  // Result is op2 << 12.
	} alu_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One decoded instruction, 60 bits wide.
	typedef struct packed {
		logic                  valid;
		alu_op_e               op;
		logic [`DI_REG_AW-1:0] rd;
		logic [`DI_REG_AW-1:0] rs1;
		logic [`DI_REG_AW-1:0] rs2;
		logic                  use_imm; // Operand 2 comes from imm.
		logic [`DI_XLEN-1:0]   imm;
		logic [6:0]            pad;
	} instr_t;

	// Combinational ALU result of the execute stage.
	typedef struct packed {
		logic                  valid; // Never set for rd 0.
		logic [`DI_REG_AW-1:0] rd;
		logic [`DI_XLEN-1:0]   data;
	} ex_result_t;

	// Writeback register, drives one register-file write port.
	typedef struct packed {
		logic                  wen;
		logic [`DI_REG_AW-1:0] rd;
		logic [`DI_XLEN-1:0]   data;
	} wb_t;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst,

	input  logic [`DI_REG_AW-1:0] raddr1_a,
	input  logic [`DI_REG_AW-1:0] raddr2_a,
	input  logic [`DI_REG_AW-1:0] raddr1_b,
	input  logic [`DI_REG_AW-1:0] raddr2_b,

	output logic [`DI_XLEN-1:0]   rdata1_a,
	output logic [`DI_XLEN-1:0]   rdata2_a,
	output logic [`DI_XLEN-1:0]   rdata1_b,
	output logic [`DI_XLEN-1:0]   rdata2_b,

	input  dual_issue_pkg::wb_t   wb_a,
	input  dual_issue_pkg::wb_t   wb_b
);

	logic [`DI_XLEN-1:0] regs [`DI_REG_COUNT];

	// Same collision rule as the array write, so a reader never sees a
	// value that will not land.
	function automatic logic [`DI_XLEN-1:0] read_port(input logic [`DI_REG_AW-1:0] addr);
		logic [`DI_XLEN-1:0] val;
		if (wb_b.wen && wb_b.rd == addr) begin
			val = wb_b.data; // Slave lane has priority.
		end else if (wb_a.wen && wb_a.rd == addr) begin
			val = wb_a.data;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read ports with writeback bypass
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rdata1_a = read_port(raddr1_a);
		rdata2_a = read_port(raddr2_a);
		rdata1_b = read_port(raddr1_b);
		rdata2_b = read_port(raddr2_b);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic wr_conflict;

	assign wr_conflict = wb_a.wen && wb_b.wen && (wb_a.rd == wb_b.rd);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DI_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_a.wen && !wr_conflict) begin
				regs[wb_a.rd] <= wb_a.data; // Dropped when the slave hits the same rd.
			end
			if (wb_b.wen) begin
				regs[wb_b.rd] <= wb_b.data;
			end
		end
	end

	// Entry 0 stays zero only because the lanes never write it.
	a_no_wr_zero_a: assert property (
		@(posedge clk) disable iff (rst)
		wb_a.wen |-> wb_a.rd != '0
	) else $error("lane a writeback enabled for register 0");

	a_no_wr_zero_b: assert property (
		@(posedge clk) disable iff (rst)
		wb_b.wen |-> wb_b.rd != '0
	) else $error("lane b writeback enabled for register 0");

endmodule

/* hw/operand_forward.sv */
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module operand_forward (
	input  dual_issue_pkg::instr_t     instr_a,
	input  dual_issue_pkg::instr_t     instr_b,

	input  dual_issue_pkg::ex_result_t ex_a,
	input  dual_issue_pkg::ex_result_t ex_b,

	input  logic [`DI_XLEN-1:0]        rf1_a,
	input  logic [`DI_XLEN-1:0]        rf2_a,
	input  logic [`DI_XLEN-1:0]        rf1_b,
	input  logic [`DI_XLEN-1:0]        rf2_b,

	output logic [`DI_XLEN-1:0]        op1_a,
	output logic [`DI_XLEN-1:0]        op2_a,
	output logic [`DI_XLEN-1:0]        op1_b,
	output logic [`DI_XLEN-1:0]        op2_b
);

	// Execute stage beats the register file; slave beats master.
	function automatic logic [`DI_XLEN-1:0] pick(
		input logic [`DI_REG_AW-1:0]       rs,
		input logic [`DI_XLEN-1:0]         rf_data,
		input dual_issue_pkg::ex_result_t  exa,
		input dual_issue_pkg::ex_result_t  exb
	);
		logic [`DI_XLEN-1:0] val;
		if (exb.valid && exb.rd == rs) begin
			val = exb.data;
		end else if (exa.valid && exa.rd == rs) begin
			val = exa.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	logic [`DI_XLEN-1:0] src2_a;
	logic [`DI_XLEN-1:0] src2_b;

	always_comb begin
		op1_a  = pick(instr_a.rs1, rf1_a, ex_a, ex_b);
		src2_a = pick(instr_a.rs2, rf2_a, ex_a, ex_b);
		op1_b  = pick(instr_b.rs1, rf1_b, ex_a, ex_b);
		src2_b = pick(instr_b.rs2, rf2_b, ex_a, ex_b);

		op2_a = instr_a.use_imm ? instr_a.imm : src2_a;
		op2_b = instr_b.use_imm ? instr_b.imm : src2_b;
	end

	// The lanes own the rd 0 filter, so forwarding trusts ex valid as is.
	always_comb begin
		if (ex_a.valid) begin
			a_ex_a_rd: assert (ex_a.rd != '0)
				else $error("lane a execute result valid for register 0");
		end
		if (ex_b.valid) begin
			a_ex_b_rd: assert (ex_b.rd != '0)
				else $error("lane b execute result valid for register 0");
		end
	end

endmodule

/* hw/issue_lane.sv */
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module issue_lane (
	input  logic                       clk,
	input  logic                       rst,

	input  dual_issue_pkg::instr_t     instr,
	input  logic [`DI_XLEN-1:0]        op1,
	input  logic [`DI_XLEN-1:0]        op2,

	output dual_issue_pkg::ex_result_t ex,
	output dual_issue_pkg::wb_t        wb
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute stage registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic                    ex_valid;
	dual_issue_pkg::alu_op_e ex_op;
	logic [`DI_REG_AW-1:0]   ex_rd;
	logic [`DI_XLEN-1:0]     ex_op1;
	logic [`DI_XLEN-1:0]     ex_op2;

	logic [`DI_XLEN-1:0]     alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= instr.valid;
		end
		ex_op  <= instr.op;
		ex_rd  <= instr.rd;
		ex_op1 <= op1; // Already forwarded and imm-selected.
		ex_op2 <= op2;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		unique case (ex_op)
			dual_issue_pkg::op_add: alu_result = ex_op1 + ex_op2;
			dual_issue_pkg::op_sub: alu_result = ex_op1 - ex_op2;
			dual_issue_pkg::op_and: alu_result = ex_op1 & ex_op2;
			dual_issue_pkg::op_or:  alu_result = ex_op1 | ex_op2;
			dual_issue_pkg::op_xor: alu_result = ex_op1 ^ ex_op2;
			dual_issue_pkg::op_sll: alu_result = ex_op1 << ex_op2[4:0];
			dual_issue_pkg::op_srl: alu_result = ex_op1 >> ex_op2[4:0];
			dual_issue_pkg::op_lui: alu_result = ex_op2 << 12;
			default:                alu_result = '0;
		endcase
	end

	// Register 0 is filtered here, once, for both forwarding and writeback.
	assign ex.valid = ex_valid && (ex_rd != '0);
	assign ex.rd    = ex_rd;
	assign ex.data  = alu_result;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Writeback register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			wb.wen <= 1'b0;
		end else begin
			wb.wen <= ex.valid;
		end
		wb.rd   <= ex.rd;
		wb.data <= alu_result;
	end

	// A valid instruction must carry one of the eight decoded opcodes.
	a_op_known: assert property (
		@(posedge clk) disable iff (rst)
		ex_valid |-> ex_op inside {
			dual_issue_pkg::op_add, dual_issue_pkg::op_sub,
			dual_issue_pkg::op_and, dual_issue_pkg::op_or,
			dual_issue_pkg::op_xor, dual_issue_pkg::op_sll,
			dual_issue_pkg::op_srl, dual_issue_pkg::op_lui
		}
	) else $error("execute stage holds an unknown opcode %0d", ex_op);

endmodule

/* hw/dual_issue_top.sv */
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module dual_issue_top (
	input  logic                   clk,
	input  logic                   rst,

	input  dual_issue_pkg::instr_t instr_a,
	input  dual_issue_pkg::instr_t instr_b,

	output dual_issue_pkg::wb_t    wb_a,
	output dual_issue_pkg::wb_t    wb_b
);

	logic [`DI_XLEN-1:0]        rf1_a;
	logic [`DI_XLEN-1:0]        rf2_a;
	logic [`DI_XLEN-1:0]        rf1_b;
	logic [`DI_XLEN-1:0]        rf2_b;

	logic [`DI_XLEN-1:0]        op1_a;
	logic [`DI_XLEN-1:0]        op2_a;
	logic [`DI_XLEN-1:0]        op1_b;
	logic [`DI_XLEN-1:0]        op2_b;

	dual_issue_pkg::ex_result_t ex_a;
	dual_issue_pkg::ex_result_t ex_b;

	// Lane a is the master and uses write port 1, lane b uses port 2.
	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.raddr1_a (instr_a.rs1),
		.raddr2_a (instr_a.rs2),
		.raddr1_b (instr_b.rs1),
		.raddr2_b (instr_b.rs2),
		.rdata1_a (rf1_a),
		.rdata2_a (rf2_a),
		.rdata1_b (rf1_b),
		.rdata2_b (rf2_b),
		.wb_a     (wb_a),
		.wb_b     (wb_b)
	);

	operand_forward u_operand_forward (
		.instr_a (instr_a),
		.instr_b (instr_b),
		.ex_a    (ex_a),
		.ex_b    (ex_b),
		.rf1_a   (rf1_a),
		.rf2_a   (rf2_a),
		.rf1_b   (rf1_b),
		.rf2_b   (rf2_b),
		.op1_a   (op1_a),
		.op2_a   (op2_a),
		.op1_b   (op1_b),
		.op2_b   (op2_b)
	);

	issue_lane lane_a (
		.clk   (clk),
		.rst   (rst),
		.instr (instr_a),
		.op1   (op1_a),
		.op2   (op2_a),
		.ex    (ex_a),
		.wb    (wb_a)
	);

	issue_lane lane_b (
		.clk   (clk),
		.rst   (rst),
		.instr (instr_b),
		.op1   (op1_b),
		.op2   (op2_b),
		.ex    (ex_b),
		.wb    (wb_b)
	);

endmodule

/* verif/dual_issue_tb.sv */
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module dual_issue_tb;

	localparam int TABLE_LEN    = 24;
	localparam int RAND_PACKETS = 200;
	localparam int WATCHDOG_NS  = (TABLE_LEN + RAND_PACKETS + 40) * 8 * 2;

	localparam dual_issue_pkg::alu_op_e add_op = dual_issue_pkg::op_add;
	localparam dual_issue_pkg::alu_op_e sub_op = dual_issue_pkg::op_sub;
	localparam dual_issue_pkg::alu_op_e and_op = dual_issue_pkg::op_and;
	localparam dual_issue_pkg::alu_op_e or_op  = dual_issue_pkg::op_or;
	localparam dual_issue_pkg::alu_op_e xor_op = dual_issue_pkg::op_xor;
	localparam dual_issue_pkg::alu_op_e sll_op = dual_issue_pkg::op_sll;
	localparam dual_issue_pkg::alu_op_e srl_op = dual_issue_pkg::op_srl;
	localparam dual_issue_pkg::alu_op_e lui_op = dual_issue_pkg::op_lui;
	localparam dual_issue_pkg::instr_t  nop    = '0;

	// One packet and the data each lane must write back for it.
	typedef struct packed {
		dual_issue_pkg::instr_t a;
		dual_issue_pkg::instr_t b;
		logic [`DI_XLEN-1:0]    exp_a;
		logic [`DI_XLEN-1:0]    exp_b;
	} row_t;

	logic                   clk = 1'b0;
	logic                   rst;
	dual_issue_pkg::instr_t instr_a;
	dual_issue_pkg::instr_t instr_b;
	dual_issue_pkg::wb_t    wb_a;
	dual_issue_pkg::wb_t    wb_b;

	row_t                   rows [TABLE_LEN];
	int                     n_rows;
	logic [`DI_XLEN-1:0]    shadow [`DI_REG_COUNT]; // Architectural register state.
	dual_issue_pkg::wb_t    exp_a_q [$];
	dual_issue_pkg::wb_t    exp_b_q [$];
	logic [31:0]            rng_state = 32'hcd2f3671;
	int                     n_checks;
	int                     n_errors;

	dual_issue_top DUT (
		.clk     (clk),
		.rst     (rst),
		.instr_a (instr_a),
		.instr_b (instr_b),
		.wb_a    (wb_a),
		.wb_b    (wb_b)
	);

	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and reference helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic dual_issue_pkg::instr_t ins(input int v, input dual_issue_pkg::alu_op_e op,
			input int rd, input int rs1, input int rs2, input int ui, input int imm);
		dual_issue_pkg::instr_t p;
		p         = '0;
		p.valid   = v[0];
		p.op      = op;
		p.rd      = rd[`DI_REG_AW-1:0];
		p.rs1     = rs1[`DI_REG_AW-1:0];
		p.rs2     = rs2[`DI_REG_AW-1:0];
		p.use_imm = ui[0];
		p.imm     = imm;
		return p;
	endfunction

	task automatic set_row(input dual_issue_pkg::instr_t a, input dual_issue_pkg::instr_t b,
			input logic [`DI_XLEN-1:0] ea, input logic [`DI_XLEN-1:0] eb);
		rows[n_rows] = '{a, b, ea, eb};
		n_rows++;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic random_instr(output dual_issue_pkg::instr_t p);
		logic [31:0] r;
		rng_state = xorshift32(rng_state);
		r = rng_state;
		rng_state = xorshift32(rng_state);
		p = '0;
		p.valid   = r[0] | r[1]; // Three in four slots carry an instruction.
		p.op      = dual_issue_pkg::alu_op_e'({1'b0, r[4:2]});
		p.rd      = r[5] ? r[10:6] : {2'b00, r[8:6]}; // Low registers often, for hazards.
		p.rs1     = r[11] ? r[16:12] : {2'b00, r[14:12]};
		p.rs2     = r[17] ? r[22:18] : {2'b00, r[20:18]};
		p.use_imm = r[23];
		p.imm     = rng_state;
	endtask

	function automatic logic [`DI_XLEN-1:0] alu_model(input dual_issue_pkg::alu_op_e op,
			input logic [`DI_XLEN-1:0] x, input logic [`DI_XLEN-1:0] y);
		case (op)
			dual_issue_pkg::op_add: return x + y;
			dual_issue_pkg::op_sub: return x - y;
			dual_issue_pkg::op_and: return x & y;
			dual_issue_pkg::op_or:  return x | y;
			dual_issue_pkg::op_xor: return x ^ y;
			dual_issue_pkg::op_sll: return x << y[4:0];
			dual_issue_pkg::op_srl: return x >> y[4:0];
			dual_issue_pkg::op_lui: return y << 12;
			default:                return '0;
		endcase
	endfunction

	function automatic logic [`DI_XLEN-1:0] model_result(input dual_issue_pkg::instr_t p);
		return alu_model(p.op, shadow[p.rs1], p.use_imm ? p.imm : shadow[p.rs2]);
	endfunction

	function automatic dual_issue_pkg::wb_t expect_wb(input dual_issue_pkg::instr_t p,
			input logic [`DI_XLEN-1:0] d);
		return '{p.valid && (p.rd != '0), p.rd, d};
	endfunction

	// Master first, so a same-rd write from the slave lands last.
	task automatic commit(input dual_issue_pkg::instr_t pa, input dual_issue_pkg::instr_t pb,
			input logic [`DI_XLEN-1:0] da, input logic [`DI_XLEN-1:0] db);
		if (pa.valid && pa.rd != '0) shadow[pa.rd] = da;
		if (pb.valid && pb.rd != '0) shadow[pb.rd] = db;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		n_checks++;
		if (got !== expected) begin
			n_errors++;
			$display("error: time %0t signal %s expected 0x%08h got 0x%08h",
				$time, name, expected, got);
		end
	endtask

	task automatic compare_wb(input string lane, input dual_issue_pkg::wb_t got,
			input dual_issue_pkg::wb_t expected);
		check({lane, ".wen"}, 32'(got.wen), 32'(expected.wen));
		if (expected.wen) begin // rd and data mean nothing without wen.
			check({lane, ".rd"}, 32'(got.rd), 32'(expected.rd));
			check({lane, ".data"}, got.data, expected.data);
		end
	endtask

	// Checks the packet from two cycles back, then drives the next one.
	task automatic run_cycle(input dual_issue_pkg::instr_t pa, input dual_issue_pkg::instr_t pb,
			input dual_issue_pkg::wb_t ea, input dual_issue_pkg::wb_t eb);
		@(posedge clk);
		#1;
		compare_wb("wb_a", wb_a, exp_a_q.pop_front());
		compare_wb("wb_b", wb_b, exp_b_q.pop_front());
		instr_a = pa;
		instr_b = pb;
		exp_a_q.push_back(ea);
		exp_b_q.push_back(eb);
	endtask

	task automatic fill_table();
		set_row(ins(1, add_op, 1, 0, 0, 1, 'h5), ins(1, or_op, 3, 7, 9, 0, 0), 'h5, 'h0);
		set_row(ins(1, add_op, 2, 1, 0, 1, 'h3), ins(1, sub_op, 4, 1, 0, 1, 'h1), 'h8, 'h4);
		set_row(ins(1, lui_op, 5, 0, 0, 1, 'h12345), nop, 'h12345000, 'h0);
		set_row(ins(1, add_op, 6, 2, 4, 0, 0), ins(1, xor_op, 7, 5, 0, 1, 'hff), 'hc, 'h123450ff);
		set_row(nop, nop, 'h0, 'h0);
		set_row(ins(1, sub_op, 8, 6, 1, 0, 0), ins(1, and_op, 9, 7, 0, 1, 'hf0f0), 'h7, 'h50f0);
		set_row(nop, nop, 'h0, 'h0);
		set_row(nop, nop, 'h0, 'h0);
		set_row(ins(1, or_op, 10, 8, 9, 0, 0), ins(1, sll_op, 11, 1, 0, 1, 'h4), 'h50f7, 'h50);
		set_row(ins(1, srl_op, 12, 5, 2, 0, 0), ins(1, sll_op, 13, 6, 4, 0, 0), 'h123450, 'hc0);
		set_row(ins(1, srl_op, 14, 5, 0, 1, 'h24), ins(1, sll_op, 15, 1, 0, 1, 'h21),
			'h1234500, 'ha);
		set_row(ins(1, and_op, 16, 7, 5, 0, 0), ins(1, xor_op, 17, 7, 5, 0, 0), 'h12345000, 'hff);
		set_row(ins(1, sub_op, 18, 0, 0, 1, 'h1), ins(1, lui_op, 19, 0, 0, 1, 'hfffff),
			'hffffffff, 'hfffff000);
		set_row(ins(1, add_op, 20, 0, 0, 1, 'h111), ins(1, add_op, 20, 0, 0, 1, 'h222), 'h111, 'h222);
		set_row(ins(1, add_op, 21, 20, 0, 1, 'h0), ins(1, add_op, 22, 21, 0, 1, 'h1), 'h222, 'h1);
		set_row(ins(1, add_op, 23, 20, 0, 0, 0), ins(1, add_op, 24, 21, 0, 1, 'h0), 'h222, 'h222);
		set_row(nop, nop, 'h0, 'h0);
		set_row(ins(1, add_op, 25, 20, 0, 1, 'h0), ins(1, or_op, 26, 22, 21, 0, 0), 'h222, 'h223);
		set_row(ins(1, add_op, 0, 1, 0, 1, 'd100), ins(1, lui_op, 0, 0, 0, 1, 'h1), 'h0, 'h0);
		set_row(ins(1, add_op, 27, 0, 0, 1, 'h3), ins(1, or_op, 28, 0, 0, 1, 'h0), 'h3, 'h0);
		set_row(ins(1, add_op, 29, 0, 0, 0, 0), ins(1, sub_op, 30, 1, 0, 0, 0), 'h0, 'h5);
		set_row(ins(0, add_op, 1, 0, 0, 1, 'd99), nop, 'h0, 'h0); // Idle slot must not write.
		set_row(ins(1, add_op, 31, 1, 0, 1, 'h0), ins(1, xor_op, 2, 2, 2, 0, 0), 'h5, 'h0);
		set_row(ins(1, add_op, 3, 2, 0, 1, 'h1), ins(1, add_op, 4, 31, 6, 0, 0), 'h1, 'h11);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		dual_issue_pkg::instr_t pa;
		dual_issue_pkg::instr_t pb;
		logic [`DI_XLEN-1:0]    da;
		logic [`DI_XLEN-1:0]    db;
		rst      = 1'b1;
		instr_a  = '0;
		instr_b  = '0;
		n_rows   = 0;
		n_checks = 0;
		n_errors = 0;
		for (int i = 0; i < `DI_REG_COUNT; i++) shadow[i] = '0;
		fill_table();
		repeat (2) begin
			exp_a_q.push_back('0); // Nothing in flight right after reset.
			exp_b_q.push_back('0);
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			commit(rows[i].a, rows[i].b, rows[i].exp_a, rows[i].exp_b);
			run_cycle(rows[i].a, rows[i].b, expect_wb(rows[i].a, rows[i].exp_a),
				expect_wb(rows[i].b, rows[i].exp_b));
		end
		for (int i = 0; i < RAND_PACKETS; i++) begin
			random_instr(pa);
			random_instr(pb);
			da = model_result(pa); // Both lanes read before either writes.
			db = model_result(pb);
			commit(pa, pb, da, db);
			run_cycle(pa, pb, expect_wb(pa, da), expect_wb(pb, db));
		end
		repeat (2) run_cycle(nop, nop, '0, '0);
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* dual_issue_rf.f */
+incdir+include
hw/dual_issue_pkg.sv
hw/reg_file.sv
hw/operand_forward.sv
hw/issue_lane.sv
hw/dual_issue_top.sv
verif/dual_issue_tb.sv

/* Makefile */
# Verilator build and run for the dual-issue register file testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= dual_issue_tb
FILELIST  ?= dual_issue_rf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes.
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
